// ==== verilog/rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int XLEN      = 64;
  localparam int ILEN      = 32;  // instruction and wishbone data width
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 64'd4;

  // only the major opcodes the core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_REQ
  } fetch_state_e;

  // read-only wishbone classic master
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [XLEN-1:0] adr;
  } wb_m2s_t;

  typedef struct packed {
    logic            ack;
    logic [ILEN-1:0] dat;
  } wb_s2m_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      instr;
    alu_op_e              alu_op;
    logic                 use_imm;  // operand b from imm
    logic [XLEN-1:0]      imm;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [REG_IDX_W-1:0] rd;
    logic                 wben;     // already low for rd == x0
  } id_ex_t;

  // EX/LS and LS/WB contents, also the forwarding source
  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      instr;
    logic [REG_IDX_W-1:0] rd;
    logic                 wben;
    logic [XLEN-1:0]      result;
  } stage_res_t;

  typedef struct packed {
    logic                 en;
    logic [REG_IDX_W-1:0] addr;
    logic [XLEN-1:0]      data;
  } rf_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      instr;
    logic                 we;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      data;
  } commit_t;

endpackage

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  rv_core_pkg::wb_s2m_t wb_s2m_i,
  output rv_core_pkg::wb_m2s_t wb_m2s_o,
  output rv_core_pkg::if_id_t  if_id_o
);

  rv_core_pkg::fetch_state_e       state_q;
  logic [rv_core_pkg::XLEN-1:0]    pc_q;
  logic                            req;
  logic                            hit;

  assign req = (state_q == rv_core_pkg::FETCH_REQ);
  assign hit = req & wb_s2m_i.ack;  // instruction accepted this cycle

  // cyc and stb come from the same term, adr only moves after an ack
  always_comb begin
    wb_m2s_o.cyc = req;
    wb_m2s_o.stb = req;
    wb_m2s_o.adr = pc_q;
  end

  // one idle cycle out of reset, then request forever
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= rv_core_pkg::FETCH_IDLE;
      pc_q    <= rv_core_pkg::RESET_PC;
    end else begin
      state_q <= rv_core_pkg::FETCH_REQ;
      if (hit) begin
        pc_q <= pc_q + rv_core_pkg::PC_STEP;  // sequential only
      end
    end
  end

  // IF/ID register, bubble when no ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      if_id_o.valid <= 1'b0;
    end else begin
      if_id_o.valid <= hit;
      if (hit) begin
        if_id_o.pc    <= pc_q;
        if_id_o.instr <= wb_s2m_i.dat;
      end
    end
  end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] rs1_i,
  input  logic [rv_core_pkg::REG_IDX_W-1:0] rs2_i,
  input  rv_core_pkg::rf_wr_t               rd_wr_i,
  output logic [rv_core_pkg::XLEN-1:0]      rs1_val_o,
  output logic [rv_core_pkg::XLEN-1:0]      rs2_val_o
);

  logic [rv_core_pkg::XLEN-1:0] regs_q [rv_core_pkg::NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < rv_core_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rd_wr_i.en) begin
      regs_q[rd_wr_i.addr] <= rd_wr_i.data;
    end
  end

  // x0 reads zero; a write in the same cycle is seen by decode right away
  assign rs1_val_o = (rs1_i == '0) ? '0 :
                     (rd_wr_i.en && rd_wr_i.addr == rs1_i) ? rd_wr_i.data :
                     regs_q[rs1_i];

  assign rs2_val_o = (rs2_i == '0) ? '0 :
                     (rd_wr_i.en && rd_wr_i.addr == rs2_i) ? rd_wr_i.data :
                     regs_q[rs2_i];

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  rv_core_pkg::if_id_t if_id_i,
  input  rv_core_pkg::rf_wr_t rf_wr_i,
  output rv_core_pkg::id_ex_t id_ex_o
);

  rv_core_pkg::opcode_e            opcode;
  logic [2:0]                      funct3;
  logic                            alt;      // instr[30], sub / sra select
  logic [rv_core_pkg::XLEN-1:0]    imm_i;
  logic [rv_core_pkg::XLEN-1:0]    imm_u;
  logic [rv_core_pkg::XLEN-1:0]    rs1_val;
  logic [rv_core_pkg::XLEN-1:0]    rs2_val;
  rv_core_pkg::id_ex_t             id_ex_d;

  assign opcode = rv_core_pkg::opcode_e'(if_id_i.instr[6:0]);
  assign funct3 = if_id_i.instr[14:12];
  assign alt    = if_id_i.instr[30];
  assign imm_i  = {{52{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
  assign imm_u  = {{32{if_id_i.instr[31]}}, if_id_i.instr[31:12], 12'b0};

  // shared funct3 map for OP and OP-IMM, sub only exists in OP
  function automatic rv_core_pkg::alu_op_e alu_decode(
    input logic [2:0] f3,
    input logic       f7_alt,
    input logic       is_reg
  );
    case (f3)
      3'b000:  return (is_reg && f7_alt) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  return rv_core_pkg::ALU_SLL;
      3'b010:  return rv_core_pkg::ALU_SLT;
      3'b011:  return rv_core_pkg::ALU_SLTU;
      3'b100:  return rv_core_pkg::ALU_XOR;
      3'b101:  return f7_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  return rv_core_pkg::ALU_OR;
      default: return rv_core_pkg::ALU_AND;
    endcase
  endfunction

  reg_file reg_file_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rs1_i     (if_id_i.instr[19:15]),
    .rs2_i     (if_id_i.instr[24:20]),
    .rd_wr_i   (rf_wr_i),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val)
  );

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.valid   = if_id_i.valid;
    id_ex_d.pc      = if_id_i.pc;
    id_ex_d.instr   = if_id_i.instr;
    id_ex_d.rs1     = if_id_i.instr[19:15];
    id_ex_d.rs2     = if_id_i.instr[24:20];
    id_ex_d.rd      = if_id_i.instr[11:7];
    id_ex_d.rs1_val = rs1_val;
    id_ex_d.rs2_val = rs2_val;
    id_ex_d.alu_op  = rv_core_pkg::ALU_ADD;
    case (opcode)
      rv_core_pkg::OPC_OP: begin
        id_ex_d.alu_op = alu_decode(funct3, alt, 1'b1);
        id_ex_d.wben   = 1'b1;
      end
      rv_core_pkg::OPC_OP_IMM: begin
        id_ex_d.alu_op  = alu_decode(funct3, alt, 1'b0);
        id_ex_d.use_imm = 1'b1;
        id_ex_d.imm     = imm_i;
        id_ex_d.wben    = 1'b1;
      end
      rv_core_pkg::OPC_LUI: begin
        id_ex_d.alu_op  = rv_core_pkg::ALU_PASS_B;
        id_ex_d.use_imm = 1'b1;
        id_ex_d.imm     = imm_u;
        id_ex_d.wben    = 1'b1;
      end
      default: ;  // anything else retires as a nop
    endcase
    if (id_ex_d.rd == '0) begin
      id_ex_d.wben = 1'b0;  // x0 never written or forwarded
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_ex_o.valid <= 1'b0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  rv_core_pkg::id_ex_t     id_ex_i,
  input  rv_core_pkg::stage_res_t wb_res_i,
  output rv_core_pkg::stage_res_t ls_res_o
);

  logic [rv_core_pkg::XLEN-1:0] op_a;
  logic [rv_core_pkg::XLEN-1:0] op_b_reg;
  logic [rv_core_pkg::XLEN-1:0] op_b;
  logic [5:0]                   shamt;
  logic [rv_core_pkg::XLEN-1:0] alu_res;
  rv_core_pkg::stage_res_t      ls_d;

  // youngest producer wins: ls stage, then wb stage, then decode read
  function automatic logic [rv_core_pkg::XLEN-1:0] fwd(
    input logic [rv_core_pkg::REG_IDX_W-1:0] idx,
    input logic [rv_core_pkg::XLEN-1:0]      id_val,
    input rv_core_pkg::stage_res_t           ls,
    input rv_core_pkg::stage_res_t           wb
  );
    if (ls.valid && ls.wben && ls.rd == idx) begin
      return ls.result;
    end
    if (wb.valid && wb.wben && wb.rd == idx) begin
      return wb.result;
    end
    return id_val;
  endfunction

  always_comb begin
    op_a     = fwd(id_ex_i.rs1, id_ex_i.rs1_val, ls_res_o, wb_res_i);
    op_b_reg = fwd(id_ex_i.rs2, id_ex_i.rs2_val, ls_res_o, wb_res_i);
  end

  assign op_b  = id_ex_i.use_imm ? id_ex_i.imm : op_b_reg;
  assign shamt = op_b[5:0];  // rv64 shift amount

  always_comb begin
    case (id_ex_i.alu_op)
      rv_core_pkg::ALU_ADD:    alu_res = op_a + op_b;
      rv_core_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_core_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_core_pkg::ALU_SLT: begin
        alu_res = {{(rv_core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      rv_core_pkg::ALU_SLTU: begin
        alu_res = {{(rv_core_pkg::XLEN-1){1'b0}}, op_a < op_b};
      end
      rv_core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
      rv_core_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_core_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_core_pkg::ALU_PASS_B: alu_res = op_b;  // lui immediate
      default:                 alu_res = '0;
    endcase
  end

  always_comb begin
    ls_d.valid  = id_ex_i.valid;
    ls_d.pc     = id_ex_i.pc;
    ls_d.instr  = id_ex_i.instr;
    ls_d.rd     = id_ex_i.rd;
    ls_d.wben   = id_ex_i.wben;
    ls_d.result = alu_res;
  end

  // EX/LS register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ls_res_o.valid <= 1'b0;
    end else begin
      ls_res_o <= ls_d;
    end
  end

endmodule

// ==== verilog/retire_stage.sv ====
`timescale 1ns/1ps

module retire_stage (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  rv_core_pkg::stage_res_t ls_res_i,
  output rv_core_pkg::stage_res_t wb_res_o,
  output rv_core_pkg::rf_wr_t     rf_wr_o,
  output rv_core_pkg::commit_t    commit_o
);

  logic wr_en;

  // LS/WB register, ls stage only carries the alu result through
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_res_o.valid <= 1'b0;
    end else begin
      wb_res_o <= ls_res_i;
    end
  end

  assign wr_en = wb_res_o.valid & wb_res_o.wben;

  // register write lands in the same cycle as commit
  always_comb begin
    rf_wr_o.en   = wr_en;
    rf_wr_o.addr = wb_res_o.rd;
    rf_wr_o.data = wb_res_o.result;
  end

  // commit port for the external checker
  always_comb begin
    commit_o.valid = wb_res_o.valid;
    commit_o.pc    = wb_res_o.pc;
    commit_o.instr = wb_res_o.instr;
    commit_o.we    = wr_en;
    commit_o.rd    = wb_res_o.rd;
    commit_o.data  = wb_res_o.result;  // shown even when we is low
  end

endmodule

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  rv_core_pkg::wb_s2m_t wb_s2m_i,
  output rv_core_pkg::wb_m2s_t wb_m2s_o,
  output rv_core_pkg::commit_t commit_o
);

  rv_core_pkg::if_id_t     if_id;
  rv_core_pkg::id_ex_t     id_ex;
  rv_core_pkg::stage_res_t ls_res;  // EX/LS, first forwarding source
  rv_core_pkg::stage_res_t wb_res;  // LS/WB, second forwarding source
  rv_core_pkg::rf_wr_t     rf_wr;

  fetch_unit fetch_unit_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_s2m_i (wb_s2m_i),
    .wb_m2s_o (wb_m2s_o),
    .if_id_o  (if_id)
  );

  decode_stage decode_stage_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .if_id_i (if_id),
    .rf_wr_i (rf_wr),
    .id_ex_o (id_ex)
  );

  ex_stage ex_stage_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .id_ex_i  (id_ex),
    .wb_res_i (wb_res),
    .ls_res_o (ls_res)
  );

  retire_stage retire_stage_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ls_res_i (ls_res),
    .wb_res_o (wb_res),
    .rf_wr_o  (rf_wr),
    .commit_o (commit_o)
  );

endmodule

// ==== verif/rv_core_chk.sv ====
`timescale 1ns/1ps

module rv_core_chk (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input rv_core_pkg::wb_s2m_t wb_s2m_i,
  input rv_core_pkg::wb_m2s_t wb_m2s_o,
  input rv_core_pkg::commit_t commit_o
);

  cyc_eq_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_m2s_o.cyc == wb_m2s_o.stb)
    else $error("wishbone cyc and stb differ");

  // classic bus, address held until the slave acks
  adr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_m2s_o.stb && !wb_s2m_i.ack) |=> $stable(wb_m2s_o.adr))
    else $error("fetch address moved without an ack");

  no_commit_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !commit_o.valid)
    else $error("commit valid while in reset");

  adr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_m2s_o.stb && wb_s2m_i.ack) |=>
      (wb_m2s_o.stb && wb_m2s_o.adr == $past(wb_m2s_o.adr) + rv_core_pkg::PC_STEP))
    else $error("fetch address did not step by one word after an ack");

endmodule

bind rv_core_top rv_core_chk rv_core_chk_inst (.*);

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam int MEM_DEPTH = 256;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  rv_core_pkg::wb_s2m_t wb_s2m = '0;
  rv_core_pkg::wb_m2s_t wb_m2s;
  rv_core_pkg::commit_t commit;

  logic [31:0]          imem [MEM_DEPTH];
  logic [63:0]          ref_regs [32];
  rv_core_pkg::commit_t exp_q [$];     // expected commits in program order
  int                   ack_cycle [MEM_DEPTH];
  logic [63:0]          exp_adr;
  integer               seed = 32'h1406_ff2a;
  int                   wait_max = 0;
  int                   wait_left = 0;
  int                   draw;
  int                   prog_len = 0;
  int                   cycle_cnt = 0;
  int                   commit_errs = 0;
  int                   fetch_errs = 0;
  bit                   checking = 1'b0;

  rv_core_top rv_core_top_inst (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_s2m_i (wb_s2m),
    .wb_m2s_o (wb_m2s),
    .commit_o (commit)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic int word_index(input logic [63:0] adr);
    return int'(((adr - rv_core_pkg::RESET_PC) >> 2) % MEM_DEPTH);
  endfunction

  // instruction memory, registered ack after a random number of wait cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      wb_s2m.ack <= 1'b0;
      wait_left  <= wait_max;
    end else if (wb_m2s.stb) begin
      if (wb_s2m.ack) begin
        // beat done, master is on the next word from now on
        draw = (wait_max == 0) ? 0 : $unsigned($random(seed)) % (wait_max + 1);
        wb_s2m.ack <= (draw == 0);
        wb_s2m.dat <= imem[word_index(wb_m2s.adr + rv_core_pkg::PC_STEP)];
        wait_left  <= draw - 1;
      end else if (wait_left == 0) begin
        wb_s2m.ack <= 1'b1;
        wb_s2m.dat <= imem[word_index(wb_m2s.adr)];
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  function automatic logic [31:0] r_instr(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_instr(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_instr(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  // rv64 semantics, shift amount from the low 6 bits
  function automatic logic [63:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[5:0];
      3'b010:  return {63'd0, $signed(a) < $signed(b)};
      3'b011:  return {63'd0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt)
          return $signed(a) >>> b[5:0];
        return a >> b[5:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes in program order and queues the expected commit
  task automatic append_instr(input logic [31:0] instr);
    rv_core_pkg::commit_t exp;
    logic [63:0]          a;
    a         = ref_regs[instr[19:15]];
    exp       = '0;
    exp.valid = 1'b1;
    exp.pc    = rv_core_pkg::RESET_PC + 64'(prog_len) * 4;
    exp.instr = instr;
    exp.rd    = instr[11:7];
    exp.we    = (instr[11:7] != 5'd0);
    case (instr[6:0])
      7'b0110011: exp.data = ref_alu(instr[14:12], instr[30], a, ref_regs[instr[24:20]]);
      7'b0010011: begin
        exp.data = ref_alu(instr[14:12], instr[14:12] == 3'b101 && instr[30], a,
                           {{52{instr[31]}}, instr[31:20]});
      end
      default: exp.data = {{32{instr[31]}}, instr[31:12], 12'h000};  // lui
    endcase
    if (exp.we)
      ref_regs[exp.rd] = exp.data;
    imem[prog_len] = instr;
    prog_len++;
    exp_q.push_back(exp);
  endtask

  task automatic clear_program();
    // unused words hold addi x0, x0, <word index>
    for (int i = 0; i < MEM_DEPTH; i++)
      imem[i] = {i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011};
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    exp_q.delete();
    prog_len = 0;
  endtask

  task automatic check_commit(input rv_core_pkg::commit_t got,
                              input rv_core_pkg::commit_t exp, input int latency);
    if (got.pc !== exp.pc || got.instr !== exp.instr || got.we !== exp.we ||
        got.rd !== exp.rd || (exp.we && got.data !== exp.data)) begin
      $display("FAIL commit_o pc %h instr %h we %h rd %h data %h",
               got.pc, got.instr, got.we, got.rd, got.data);
      $display("     expected pc %h instr %h we %h rd %h data %h",
               exp.pc, exp.instr, exp.we, exp.rd, exp.data);
      commit_errs++;
    end
    if (latency != 4) begin
      $display("FAIL commit_o latency for pc %h got %h exp %h", got.pc, latency, 4);
      commit_errs++;
    end
  endtask

  task automatic check_fetch_adr(input rv_core_pkg::wb_m2s_t got, input logic [63:0] exp);
    if (got.adr !== exp) begin
      $display("FAIL wb_m2s_o.adr got %h exp %h", got.adr, exp);
      fetch_errs++;
    end
  endtask

  // fetch and commit monitor
  always @(posedge clk) begin
    if (checking) begin
      if (wb_m2s.stb && wb_s2m.ack) begin
        check_fetch_adr(wb_m2s, exp_adr);
        ack_cycle[word_index(wb_m2s.adr)] = cycle_cnt;
        exp_adr = exp_adr + rv_core_pkg::PC_STEP;
      end
      if (commit.valid && exp_q.size() != 0)
        check_commit(commit, exp_q.pop_front(), cycle_cnt - ack_cycle[word_index(commit.pc)]);
    end
    cycle_cnt++;
  end

  task automatic report_and_finish(input bit timed_out);
    $display("errors: %0d commit, %0d fetch, %0d timeout", commit_errs, fetch_errs, timed_out);
    if (timed_out || commit_errs != 0 || fetch_errs != 0)
      $display("test failed");
    else
      $display("test passed");
    $finish;
  endtask

  task automatic run_program(input int max_wait);
    int limit;
    int cycles;
    limit    = exp_q.size() * (max_wait + 2) + 50;
    cycles   = 0;
    wait_max = max_wait;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    exp_adr  = rv_core_pkg::RESET_PC;
    checking = 1'b1;
    while (exp_q.size() != 0 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d commits still missing after %0d cycles", exp_q.size(), cycles);
      report_and_finish(1'b1);
    end else begin
      checking = 1'b0;
    end
  endtask

  task automatic rtype_independent();
    clear_program();
    append_instr(u_instr(5'd1, 20'h12345));
    append_instr(i_instr(3'b000, 5'd1, 5'd1, 12'h678));
    append_instr(u_instr(5'd2, 20'hfedcb));  // negative after sign extension
    append_instr(i_instr(3'b000, 5'd3, 5'd0, 12'h005));
    append_instr(r_instr(3'b000, 1'b0, 5'd5, 5'd1, 5'd2));
    append_instr(r_instr(3'b000, 1'b1, 5'd6, 5'd1, 5'd2));
    append_instr(r_instr(3'b001, 1'b0, 5'd7, 5'd1, 5'd3));
    append_instr(r_instr(3'b010, 1'b0, 5'd8, 5'd2, 5'd1));
    append_instr(r_instr(3'b011, 1'b0, 5'd9, 5'd2, 5'd1));
    append_instr(r_instr(3'b100, 1'b0, 5'd10, 5'd1, 5'd2));
    append_instr(r_instr(3'b101, 1'b0, 5'd11, 5'd2, 5'd3));
    append_instr(r_instr(3'b101, 1'b1, 5'd12, 5'd2, 5'd3));
    append_instr(r_instr(3'b110, 1'b0, 5'd13, 5'd1, 5'd2));
    append_instr(r_instr(3'b111, 1'b0, 5'd14, 5'd1, 5'd2));
    append_instr(r_instr(3'b001, 1'b0, 5'd15, 5'd2, 5'd1));  // amount above 31
    run_program(3);
  endtask

  task automatic imm_and_lui();
    clear_program();
    append_instr(u_instr(5'd1, 20'h80000));
    append_instr(i_instr(3'b000, 5'd2, 5'd1, 12'hfff));
    append_instr(i_instr(3'b010, 5'd3, 5'd1, 12'h000));
    append_instr(i_instr(3'b011, 5'd4, 5'd1, 12'hfff));
    append_instr(i_instr(3'b100, 5'd5, 5'd1, 12'h555));
    append_instr(i_instr(3'b110, 5'd6, 5'd0, 12'h7ff));
    append_instr(i_instr(3'b111, 5'd7, 5'd2, 12'h0f0));
    append_instr(i_instr(3'b001, 5'd8, 5'd2, 12'h021));  // slli 33
    append_instr(i_instr(3'b101, 5'd9, 5'd1, 12'h028));
    append_instr(i_instr(3'b101, 5'd10, 5'd1, 12'h428));  // srai 40
    append_instr(u_instr(5'd11, 20'h7ffff));
    run_program(2);
  endtask

  task automatic dependent_chain();
    clear_program();
    append_instr(i_instr(3'b000, 5'd1, 5'd0, 12'h007));
    append_instr(r_instr(3'b000, 1'b0, 5'd2, 5'd1, 5'd1));
    append_instr(i_instr(3'b000, 5'd3, 5'd1, 12'hffd));
    append_instr(r_instr(3'b000, 1'b1, 5'd4, 5'd2, 5'd1));
    append_instr(r_instr(3'b100, 1'b0, 5'd5, 5'd4, 5'd3));
    append_instr(r_instr(3'b001, 1'b0, 5'd6, 5'd5, 5'd1));
    append_instr(r_instr(3'b101, 1'b1, 5'd7, 5'd6, 5'd3));
    append_instr(i_instr(3'b000, 5'd8, 5'd0, 12'h001));
    append_instr(i_instr(3'b000, 5'd8, 5'd0, 12'h002));
    append_instr(r_instr(3'b000, 1'b0, 5'd9, 5'd8, 5'd8));  // younger x8 must win
    run_program(0);
  endtask

  task automatic zero_reg_writes();
    clear_program();
    append_instr(i_instr(3'b000, 5'd1, 5'd0, 12'h009));
    append_instr(i_instr(3'b000, 5'd0, 5'd1, 12'h005));
    append_instr(u_instr(5'd0, 20'habcde));
    append_instr(r_instr(3'b000, 1'b0, 5'd0, 5'd1, 5'd1));
    append_instr(r_instr(3'b000, 1'b0, 5'd2, 5'd0, 5'd1));
    append_instr(r_instr(3'b000, 1'b1, 5'd3, 5'd0, 5'd1));
    run_program(0);
  endtask

  initial begin
    rtype_independent();
    imm_and_lui();
    dependent_chain();
    zero_reg_writes();
    report_and_finish(1'b0);
  end

endmodule

// ==== rv_core.f ====
verilog/rv_core_pkg.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/ex_stage.sv
verilog/retire_stage.sv
verilog/rv_core_top.sv
verif/rv_core_chk.sv
verif/rv_core_tb.sv
